// File: rtl/network_config_pkg.sv
// network sizes, widths, fixed weights and threshold, imported by every datapath module
package network_config_pkg;
    localparam int NUM_INP = 4;
    localparam int NUM_OUT = 4;

    localparam int CHARGE_WIDTH = 8;
    typedef logic signed [CHARGE_WIDTH-1:0] charge_t;

    localparam int WEIGHT_WIDTH = 4;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // rows are output neurons, columns are network inputs
    localparam weight_t WEIGHTS [NUM_OUT][NUM_INP] = '{
        '{ 4'sd3,  4'sd2, -4'sd1,  4'sd1},
        '{-4'sd2,  4'sd5,  4'sd3,  4'sd0},
        '{ 4'sd7, -4'sd4,  4'sd2,  4'sd6},
        '{ 4'sd1,  4'sd1,  4'sd7, -4'sd3}
    };

    // a potential below threshold plus four products of 8 by 128 still fits in 14 bits
    localparam int POT_WIDTH = 14;
    typedef logic signed [POT_WIDTH-1:0] potential_t;

    localparam int THRESHOLD = 256;

    localparam int COUNT_WIDTH = 8;
    typedef logic [COUNT_WIDTH-1:0] spike_count_t;

    typedef logic [NUM_OUT-1:0] fire_vec_t;
endpackage

// File: rtl/dispatch_config_pkg.sv
// packet opcodes, packet field decoding and the structs passed between pipeline stages
package dispatch_config_pkg;
    import network_config_pkg::*;

    localparam int PFX_WIDTH = 3;
    typedef enum logic [PFX_WIDTH-1:0] {
        NOP = 3'd0,
        SPK = 3'd1,
        RUN = 3'd2,
        SNC = 3'd3,
        CLR = 3'd4
    } opcode_t;

    localparam int IDX_WIDTH = 2;
    typedef logic [IDX_WIDTH-1:0] inp_idx_t;

    localparam int PKT_WIDTH = 13;
    typedef logic [PKT_WIDTH-1:0] pkt_t;

    localparam int RUN_WIDTH = 10;
    typedef logic [RUN_WIDTH-1:0] run_len_t;

    // one time step handed to the neuron layer
    typedef struct packed {
        charge_t [NUM_INP-1:0] charge;
        logic                  sync;
    } net_step_t;

    typedef struct packed {
        fire_vec_t spikes;
        logic      sync;
    } fire_t;

    typedef struct packed {
        spike_count_t [NUM_OUT-1:0] count;
    } spike_counts_t;

    // the opcode sits in the top bits, everything below it is payload
    function automatic opcode_t pkt_opcode(pkt_t pkt);
        return opcode_t'(pkt[PKT_WIDTH-1 -: PFX_WIDTH]);
    endfunction

    function automatic run_len_t pkt_run_len(pkt_t pkt);
        return pkt[RUN_WIDTH-1:0];
    endfunction

    // spike packets carry the input index right above the charge
    function automatic inp_idx_t pkt_index(pkt_t pkt);
        return pkt[CHARGE_WIDTH +: IDX_WIDTH];
    endfunction

    function automatic charge_t pkt_charge(pkt_t pkt);
        return charge_t'(pkt[CHARGE_WIDTH-1:0]);
    endfunction
endpackage

// File: rtl/network_source.sv
// decode stage of the network, turns incoming packets into input charges and time steps
`timescale 1ns/100ps

module network_source
    import network_config_pkg::*;
    import dispatch_config_pkg::*;
(
    input  logic      clk,
    input  logic      arstn,
    // packet input
    input  logic      src_valid,
    input  pkt_t      src,
    output logic      src_ready,
    // step output towards the neuron layer
    output logic      net_valid,
    output net_step_t net_step,
    output logic      net_clear
);

    opcode_t               op;
    logic                  accept;
    logic                  step_load;
    logic                  last_step;
    run_len_t              run_cnt;
    logic                  sync_pending;
    charge_t [NUM_INP-1:0] inp;

    assign op        = pkt_opcode(src);
    assign accept    = src_valid && src_ready;
    assign step_load = accept && (op == RUN || op == SNC);

    // a new packet may come in while the last step of a run goes out
    assign src_ready = (run_cnt <= run_len_t'(1));
    assign net_valid = (run_cnt != '0);
    assign last_step = (run_cnt == run_len_t'(1));

    always_comb begin
        net_step.charge = inp;
        net_step.sync   = sync_pending && last_step;
    end

    always_ff @(posedge clk or negedge arstn) begin : set_run_cnt
        if (!arstn) begin
            run_cnt <= '0;
        end else if (step_load) begin
            run_cnt <= pkt_run_len(src);
        end else if (net_valid) begin
            run_cnt <= run_cnt - 1'b1;
        end
    end

    // the flag follows the most recent run packet so a stale SNC of length 0
    // cannot mark the end of a later RUN
    always_ff @(posedge clk or negedge arstn) begin : set_sync_pending
        if (!arstn) begin
            sync_pending <= 1'b0;
        end else if (step_load) begin
            sync_pending <= (op == SNC);
        end else if (last_step) begin
            sync_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin : set_net_clear
        if (!arstn) begin
            net_clear <= 1'b0;
        end else begin
            net_clear <= accept && (op == CLR);
        end
    end

    // charges apply to a single step only, then the inputs go back to zero
    always_ff @(posedge clk or negedge arstn) begin : set_inp
        if (!arstn) begin
            inp <= '0;
        end else begin
            if (net_valid || (accept && op == CLR)) begin
                inp <= '0;
            end
            // a spike taken during the last step lands after the clearing above
            if (accept && op == SPK) begin
                inp[pkt_index(src)] <= pkt_charge(src);
            end
        end
    end

endmodule

// File: rtl/neuron_layer.sv
// execute stage, a fully connected layer of integrate-and-fire neurons with fixed weights
`timescale 1ns/100ps

module neuron_layer
    import network_config_pkg::*;
    import dispatch_config_pkg::*;
(
    input  logic      clk,
    input  logic      arstn,
    // step input from the decode stage
    input  logic      net_valid,
    input  net_step_t net_step,
    input  logic      net_clear,
    // fire vector towards the spike counter
    output logic      fire_valid,
    output fire_t     fire
);

    potential_t pot      [NUM_OUT];
    potential_t pot_next [NUM_OUT];
    fire_vec_t  fire_next;

    // weighted sum of the step's charges on top of the stored potential
    always_comb begin : integrate
        potential_t sum;
        for (int o = 0; o < NUM_OUT; o++) begin
            sum = pot[o];
            for (int i = 0; i < NUM_INP; i++) begin
                sum = sum + potential_t'($signed(WEIGHTS[o][i]) * $signed(net_step.charge[i]));
            end
            if (sum >= THRESHOLD) begin
                fire_next[o] = 1'b1;
                pot_next[o]  = '0;
            end else if (sum < 0) begin
                // potentials never go negative
                fire_next[o] = 1'b0;
                pot_next[o]  = '0;
            end else begin
                fire_next[o] = 1'b0;
                pot_next[o]  = sum;
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin : set_pot
        if (!arstn) begin
            for (int o = 0; o < NUM_OUT; o++) begin
                pot[o] <= '0;
            end
        end else if (net_clear) begin
            for (int o = 0; o < NUM_OUT; o++) begin
                pot[o] <= '0;
            end
        end else if (net_valid) begin
            for (int o = 0; o < NUM_OUT; o++) begin
                pot[o] <= pot_next[o];
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin : set_fire_valid
        if (!arstn) begin
            fire_valid <= 1'b0;
        end else begin
            fire_valid <= net_valid;
        end
    end

    // the sync mark travels alongside the spikes of its step
    always_ff @(posedge clk) begin : set_fire
        if (net_valid) begin
            fire.spikes <= fire_next;
            fire.sync   <= net_step.sync;
        end
    end

endmodule

// File: rtl/spike_counter.sv
// result stage, counts spikes per output neuron and reports them at each sync step
`timescale 1ns/100ps

module spike_counter
    import network_config_pkg::*;
    import dispatch_config_pkg::*;
(
    input  logic          clk,
    input  logic          arstn,
    // fire vectors from the neuron layer
    input  logic          fire_valid,
    input  fire_t         fire,
    // report at sync points
    output logic          result_valid,
    output spike_counts_t result_counts
);

    spike_counts_t cnt;
    spike_counts_t cnt_next;

    // counts hold at their maximum instead of wrapping
    always_comb begin : add_spikes
        for (int o = 0; o < NUM_OUT; o++) begin
            if (fire.spikes[o] && cnt.count[o] != '1) begin
                cnt_next.count[o] = cnt.count[o] + 1'b1;
            end else begin
                cnt_next.count[o] = cnt.count[o];
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin : set_cnt
        if (!arstn) begin
            cnt          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= fire_valid && fire.sync;
            if (fire_valid) begin
                // a sync step closes the interval, the next one starts empty
                if (fire.sync) begin
                    cnt <= '0;
                end else begin
                    cnt <= cnt_next;
                end
            end
        end
    end

    // the reported counts include the spikes of the sync step itself
    always_ff @(posedge clk) begin : set_result_counts
        if (fire_valid && fire.sync) begin
            result_counts <= cnt_next;
        end
    end

endmodule

// File: rtl/snn_top.sv
// top level of the packet-driven spiking network, chains decode, neuron layer and counter
`timescale 1ns/100ps

module snn_top
    import dispatch_config_pkg::*;
(
    input  logic          clk,
    input  logic          arstn,
    input  logic          src_valid,
    input  pkt_t          src,
    output logic          src_ready,
    output logic          result_valid,
    output spike_counts_t result_counts
);

    logic      net_valid;
    net_step_t net_step;
    logic      net_clear;
    logic      fire_valid;
    fire_t     fire;

    network_source u_network_source (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src       (src),
        .src_ready (src_ready),
        .net_valid (net_valid),
        .net_step  (net_step),
        .net_clear (net_clear)
    );

    neuron_layer u_neuron_layer (
        .clk        (clk),
        .arstn      (arstn),
        .net_valid  (net_valid),
        .net_step   (net_step),
        .net_clear  (net_clear),
        .fire_valid (fire_valid),
        .fire       (fire)
    );

    spike_counter u_spike_counter (
        .clk           (clk),
        .arstn         (arstn),
        .fire_valid    (fire_valid),
        .fire          (fire),
        .result_valid  (result_valid),
        .result_counts (result_counts)
    );

endmodule

// File: verification/snn_checker.sv
// concurrent assertions on the decode stage outputs that the testbench binds into network_source
`timescale 1ns/100ps

module snn_checker
    import dispatch_config_pkg::*;
(
    input logic      clk,
    input logic      arstn,
    input logic      src_valid,
    input logic      src_ready,
    input logic      net_valid,
    input net_step_t net_step,
    input logic      net_clear
);

    int assert_fails = 0;

    // a clear never lands in the middle of a run
    clear_apart_from_step: assert property (@(posedge clk) disable iff (!arstn)
        !(net_clear && net_valid))
        else begin
            $error("net_clear and net_valid are high in the same cycle");
            assert_fails++;
        end

    // the source only holds off packets while steps are still going out
    stall_only_when_busy: assert property (@(posedge clk) disable iff (!arstn)
        (src_valid && !src_ready) |-> net_valid)
        else begin
            $error("src_ready is low although no step is issued");
            assert_fails++;
        end

    sync_only_on_step: assert property (@(posedge clk) disable iff (!arstn)
        net_step.sync |-> net_valid)
        else begin
            $error("net_step.sync is set outside a step");
            assert_fails++;
        end

    ready_after_reset: assert property (@(posedge clk)
        $rose(arstn) |-> src_ready)
        else begin
            $error("src_ready is low right after reset");
            assert_fails++;
        end

endmodule

// File: verification/snn_tb.sv
// testbench for snn_top that drives random packets and checks the reported counts against a model
`timescale 1ns/100ps

module snn_tb
    import network_config_pkg::*;
    import dispatch_config_pkg::*;
();

    localparam int NUM_PKTS   = 300;
    localparam int SAT_ROUNDS = 264;
    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT_NS = NUM_PKTS * 12 * CLK_PERIOD * 2;

    logic          clk;
    logic          arstn;
    logic          src_valid;
    pkt_t          src;
    logic          src_ready;
    logic          result_valid;
    spike_counts_t result_counts;

    int            seed = 87;
    int            value_errs;
    int            other_errs;
    int            assert_errs;
    int            results_seen;
    int            results_expected;
    spike_counts_t exp_q [$];
    int            model_inp [NUM_INP];
    int            model_pot [NUM_OUT];
    int            model_cnt [NUM_OUT];

    snn_top u_snn_top (.*);

    bind network_source snn_checker u_snn_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_counts(input spike_counts_t actual, input spike_counts_t expected);
        if (actual !== expected) begin
            value_errs++;
            $display("Fail at %0t: result_counts is %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_total(input int actual, input int expected);
        if (actual != expected) begin
            value_errs++;
            $display("Fail at %0t: result_valid pulses %0d, expected %0d", $time, actual, expected);
        end
    endtask

    // one time step of the layer, then the held charges are spent
    task automatic model_step(input logic sync);
        int            sum;
        spike_counts_t expected;
        for (int o = 0; o < NUM_OUT; o++) begin
            sum = model_pot[o];
            for (int i = 0; i < NUM_INP; i++) begin
                sum += int'(WEIGHTS[o][i]) * model_inp[i];
            end
            if (sum >= THRESHOLD) begin
                model_pot[o] = 0;
                if (model_cnt[o] < 255) begin
                    model_cnt[o]++;
                end
            end else begin
                model_pot[o] = (sum < 0) ? 0 : sum;
            end
        end
        for (int i = 0; i < NUM_INP; i++) begin
            model_inp[i] = 0;
        end
        if (sync) begin
            for (int o = 0; o < NUM_OUT; o++) begin
                expected.count[o] = spike_count_t'(model_cnt[o]);
                model_cnt[o] = 0;
            end
            exp_q.push_back(expected);
            results_expected++;
        end
    endtask

    task automatic model_packet(input pkt_t pkt);
        opcode_t op;
        int      len;
        op  = opcode_t'(pkt[12:10]);
        len = int'(pkt[9:0]);
        case (op)
            SPK: model_inp[pkt[9:8]] = int'($signed(pkt[7:0]));
            RUN, SNC: begin
                for (int k = 1; k <= len; k++) begin
                    model_step(op == SNC && k == len);
                end
            end
            CLR: begin
                for (int i = 0; i < NUM_INP; i++) begin
                    model_inp[i] = 0;
                end
                for (int o = 0; o < NUM_OUT; o++) begin
                    model_pot[o] = 0;
                end
            end
            default: ;
        endcase
    endtask

    // src_ready only moves at clock edges, so it is read just after them
    task automatic send_packet(input pkt_t pkt);
        src_valid = 1'b1;
        src       = pkt;
        while (!src_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        src_valid = 1'b0;
        model_packet(pkt);
    endtask

    // mostly spikes, with runs of 0 to 8 steps in between
    function automatic pkt_t random_packet();
        int          pick;
        logic [31:0] rnd;
        pkt_t        pkt;
        pick = $unsigned($random(seed)) % 11;
        rnd  = $random(seed);
        pkt  = '0;
        if (pick < 5) begin
            pkt = {SPK, rnd[9:8], rnd[7:0]};
        end else if (pick < 9) begin
            pkt = {(pick < 7) ? RUN : SNC, run_len_t'(rnd[15:0] % 9)};
        end else if (pick == 9) begin
            pkt = {CLR, 10'd0};
        end
        return pkt;
    endfunction

    always @(negedge clk) begin
        if (arstn && result_valid) begin
            results_seen++;
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("a result appeared at %0t although no sync point was due", $time);
            end else begin
                check_counts(result_counts, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the DUT stopped taking packets or reporting", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        arstn     = 1'b0;
        src_valid = 1'b0;
        src       = '0;
        for (int i = 0; i < NUM_INP; i++) begin
            model_inp[i] = 0;
        end
        for (int o = 0; o < NUM_OUT; o++) begin
            model_pot[o] = 0;
            model_cnt[o] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        arstn = 1'b1;
        repeat (NUM_PKTS) begin
            send_packet(random_packet());
        end
        // strong charges on every input, one step each, drive all counts to the limit
        repeat (SAT_ROUNDS) begin
            for (int i = 0; i < NUM_INP; i++) begin
                send_packet({SPK, inp_idx_t'(i), 8'd127});
            end
            send_packet({RUN, run_len_t'(1)});
        end
        send_packet({SNC, run_len_t'(1)});
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check_total(results_seen, results_expected);
        assert_errs = u_snn_top.u_network_source.u_snn_checker.assert_fails;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/network_config_pkg.sv
rtl/dispatch_config_pkg.sv
rtl/network_source.sv
rtl/neuron_layer.sv
rtl/spike_counter.sv
rtl/snn_top.sv
verification/snn_checker.sv
verification/snn_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module snn_tb -o snn_sim \
    || exit 1
out="$(./obj_dir/snn_sim)"
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
